// ==== src/md_data_pkg.sv ====
package md_data_pkg;

	// Field widths of the motion-update record
	localparam int COORD_W = 32;
	localparam int CELL_W = 4;

	// Particle count held in word 0
	localparam int CNT_W = 8;

	// Zero pad above the count so both cache-word views are 96 bits wide
	localparam int CNT_PAD_W = 3 * COORD_W - CNT_W;

	// One velocity component, raw word from the integrator
	typedef logic [COORD_W-1:0] coord_t;

	// Velocity triple, vx in the low word
	typedef struct packed {
		coord_t vz;
		coord_t vy;
		coord_t vx;
	} velocity_t;

	// Destination cell of a broadcast record
	typedef struct packed {
		logic [CELL_W-1:0] cell_x;
		logic [CELL_W-1:0] cell_y;
		logic [CELL_W-1:0] cell_z;
	} cell_id_t;

	// One buffer word
	// Word 0 is read through cnt
	// Words 1 and up are read through vel
	typedef union packed {
		velocity_t vel;
		struct packed {
			logic [CNT_PAD_W-1:0] pad;
			logic [CNT_W-1:0] count;
		} cnt;
	} cache_word_u;

endpackage

// ==== src/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

	// Buffer geometry
	localparam int CACHE_DEPTH = 64;
	localparam int CACHE_AW = 6;
	// Word 0 holds the count
	localparam int CACHE_CAPACITY = CACHE_DEPTH - 1;

	// Coordinates of this cell
	localparam logic [3:0] MY_CELL_X = 4'd2;
	localparam logic [3:0] MY_CELL_Y = 4'd3;
	localparam logic [3:0] MY_CELL_Z = 4'd4;
	localparam logic [11:0] MY_CELL = {MY_CELL_X, MY_CELL_Y, MY_CELL_Z};

	// APB bus and address map
	localparam int APB_AW = 13;
	localparam int APB_DW = 32;
	localparam int STATUS_SEL_BIT = 12;
	localparam int LANE_LSB = 2;
	localparam int WORD_LSB = 4;
	// Lane codes in paddr[3:2]
	localparam logic [1:0] LANE_X = 2'd0;
	localparam logic [1:0] LANE_Y = 2'd1;
	localparam logic [1:0] LANE_Z = 2'd2;
	localparam logic [1:0] LANE_BAD = 2'd3;
	// Access cycles spent waiting for buffer data before pready
	localparam int RD_WAIT = 2;

	// Motion-update FSM encoding
	localparam logic [1:0] ST_IDLE = 2'd0;
	localparam logic [1:0] ST_COLLECT = 2'd1;
	localparam logic [1:0] ST_COUNT = 2'd2;
	localparam logic [1:0] ST_SWAP = 2'd3;

endpackage

// ==== src/cell_buffer_ram.sv ====
`timescale 1ns/1ps

module cell_buffer_ram
(
	input logic clk,
	input logic [cache_cfg_pkg::CACHE_AW-1:0] addr,
	input logic we,
	input logic re,
	input md_data_pkg::cache_word_u wdata,
	output md_data_pkg::cache_word_u rdata
);
	import md_data_pkg::*;
	import cache_cfg_pkg::*;

	// Storage array
	cache_word_u mem [CACHE_DEPTH];

	// First read stage
	cache_word_u rd_q;
	logic re_q;

	// Both buffers power up empty
	initial
	begin
		for (int i = 0; i < CACHE_DEPTH; i++)
		begin
			mem[i] = '0;
		end
	end

	// Write port
	always @(posedge clk)
	begin
		if (we)
		begin
			mem[addr] <= wdata;
		end
	end

	// Array read, then output register
	// Data is on rdata two cycles after re is sampled
	always_ff @(posedge clk)
	begin
		if (re)
		begin
			rd_q <= mem[addr];
		end
		re_q <= re;
		if (re_q)
		begin
			rdata <= rd_q;
		end
	end

endmodule

// ==== src/velocity_bank_pair.sv ====
`timescale 1ns/1ps

module velocity_bank_pair
(
	input logic clk,
	input logic live_sel,
	input logic wr_en,
	input logic [cache_cfg_pkg::CACHE_AW-1:0] wr_addr,
	input md_data_pkg::cache_word_u wr_word,
	input logic rd_en,
	input logic [cache_cfg_pkg::CACHE_AW-1:0] rd_addr,
	output md_data_pkg::cache_word_u rd_word
);
	import md_data_pkg::*;
	import cache_cfg_pkg::*;

	// Per-buffer port signals
	logic [CACHE_AW-1:0] addr0;
	logic [CACHE_AW-1:0] addr1;
	logic we0;
	logic we1;
	logic re0;
	logic re1;
	cache_word_u rdata0;
	cache_word_u rdata1;

	// live_sel delayed to line up with the read data
	logic live_sel_q1;
	logic live_sel_q2;

	////////////////////////////////////////////////////////////////////////////
	// Ping-pong routing
	////////////////////////////////////////////////////////////////////////////
	// live_sel 0 means buffer 0 is live and buffer 1 is the shadow
	assign addr0 = live_sel ? wr_addr : rd_addr;
	assign addr1 = live_sel ? rd_addr : wr_addr;

	// Writes only ever reach the shadow
	assign we0 = wr_en & live_sel;
	assign we1 = wr_en & ~live_sel;

	// Reads only ever reach the live buffer
	assign re0 = rd_en & ~live_sel;
	assign re1 = rd_en & live_sel;

	////////////////////////////////////////////////////////////////////////////
	// Buffers
	////////////////////////////////////////////////////////////////////////////
	cell_buffer_ram i_buf0
	(
		.clk(clk),
		.addr(addr0),
		.we(we0),
		.re(re0),
		.wdata(wr_word),
		.rdata(rdata0)
	);

	cell_buffer_ram i_buf1
	(
		.clk(clk),
		.addr(addr1),
		.we(we1),
		.re(re1),
		.wdata(wr_word),
		.rdata(rdata1)
	);

	// Select follows the read pipeline
	// A read just before a swap still returns the buffer it addressed
	always_ff @(posedge clk)
	begin
		live_sel_q1 <= live_sel;
		live_sel_q2 <= live_sel_q1;
	end

	assign rd_word = live_sel_q2 ? rdata1 : rdata0;

endmodule

// ==== src/velocity_cache_ctrl.sv ====
`timescale 1ns/1ps

module velocity_cache_ctrl
(
	input logic clk,
	input logic rst,
	input logic update_en,
	input logic rec_valid,
	input md_data_pkg::velocity_t rec_velocity,
	input md_data_pkg::cell_id_t rec_dst,
	output logic wr_en,
	output logic [cache_cfg_pkg::CACHE_AW-1:0] wr_addr,
	output md_data_pkg::cache_word_u wr_word,
	output logic live_sel,
	output logic busy,
	output logic overflow
);
	import md_data_pkg::*;
	import cache_cfg_pkg::*;

	logic [1:0] state;

	// Records stored so far in this update
	logic [CACHE_AW-1:0] rec_cnt;

	// Beat decode
	logic hit;
	logic take;
	logic full;

	////////////////////////////////////////////////////////////////////////////
	// Destination filter
	////////////////////////////////////////////////////////////////////////////
	// Only records addressed to this cell are kept
	assign hit = rec_valid && (rec_dst == MY_CELL);

	// Beats are taken on the starting edge and all through collect
	assign take = update_en && hit && (state == ST_IDLE || state == ST_COLLECT);

	// Shadow is full once every slot after word 0 is used
	assign full = (rec_cnt == CACHE_AW'(CACHE_CAPACITY));

	////////////////////////////////////////////////////////////////////////////
	// Motion-update FSM
	////////////////////////////////////////////////////////////////////////////
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			state <= ST_IDLE;
			rec_cnt <= '0;
			wr_en <= 1'b0;
			live_sel <= 1'b0;
			busy <= 1'b0;
			overflow <= 1'b0;
		end
		else
		begin
			wr_en <= 1'b0;
			case (state)
				ST_IDLE:
				begin
					// New update, overflow starts clean
					if (update_en)
					begin
						state <= ST_COLLECT;
						busy <= 1'b1;
						overflow <= 1'b0;
					end
				end
				ST_COLLECT:
				begin
					if (!update_en)
					begin
						state <= ST_COUNT;
					end
				end
				ST_COUNT:
				begin
					// Count word goes to address 0
					wr_en <= 1'b1;
					state <= ST_SWAP;
				end
				ST_SWAP:
				begin
					// Shadow becomes live
					live_sel <= ~live_sel;
					busy <= 1'b0;
					rec_cnt <= '0;
					state <= ST_IDLE;
				end
				default:
				begin
					state <= ST_IDLE;
				end
			endcase

			// Store or drop the matching beat
			if (take)
			begin
				if (full)
				begin
					overflow <= 1'b1;
				end
				else
				begin
					wr_en <= 1'b1;
					rec_cnt <= rec_cnt + 1'b1;
				end
			end
		end
	end

	// Write address and data
	// Slots count from 1, the count word uses the union's count view
	always_ff @(posedge clk)
	begin
		if (take && !full)
		begin
			wr_addr <= rec_cnt + 1'b1;
			wr_word.vel <= rec_velocity;
		end
		else if (state == ST_COUNT)
		begin
			wr_addr <= '0;
			wr_word.cnt.pad <= '0;
			wr_word.cnt.count <= CNT_W'(rec_cnt);
		end
	end

endmodule

// ==== src/apb_cache_port.sv ====
`timescale 1ns/1ps

module apb_cache_port
(
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cache_cfg_pkg::APB_AW-1:0] paddr,
	input logic [cache_cfg_pkg::APB_DW-1:0] pwdata,
	output logic [cache_cfg_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic rd_en,
	output logic [cache_cfg_pkg::CACHE_AW-1:0] rd_addr,
	input md_data_pkg::cache_word_u rd_word,
	input logic live_sel,
	input logic busy,
	input logic overflow
);
	import cache_cfg_pkg::*;

	// Address decode
	logic setup;
	logic status_hit;
	logic in_window;
	logic [1:0] lane;
	logic [CACHE_AW-1:0] word;

	// Transfer state
	logic [1:0] wait_cnt;
	logic cache_rd;

	// Captured at setup
	logic [1:0] lane_q;
	logic word0_q;
	logic [APB_DW-1:0] resp_q;

	logic [APB_DW-1:0] lane_data;

	assign setup = psel && !penable;
	assign status_hit = paddr[STATUS_SEL_BIT];
	assign lane = paddr[LANE_LSB +: 2];
	assign word = paddr[WORD_LSB +: CACHE_AW];
	// Bits between the word index and the status select must be zero
	assign in_window = (paddr[STATUS_SEL_BIT-1 : WORD_LSB+CACHE_AW] == '0);

	////////////////////////////////////////////////////////////////////////////
	// Transfer control
	////////////////////////////////////////////////////////////////////////////
	// Decoding at setup lets short transfers finish in the first access cycle
	// Cache reads wait out the buffer latency and finish in the third
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			pready <= 1'b0;
			pslverr <= 1'b0;
			rd_en <= 1'b0;
			wait_cnt <= '0;
			cache_rd <= 1'b0;
		end
		else
		begin
			rd_en <= 1'b0;
			if (pready)
			begin
				// Transfer completes on this edge
				pready <= 1'b0;
				pslverr <= 1'b0;
				cache_rd <= 1'b0;
			end
			else if (wait_cnt != '0)
			begin
				wait_cnt <= wait_cnt - 1'b1;
				if (wait_cnt == 2'd1)
				begin
					pready <= 1'b1;
				end
			end
			else if (setup)
			begin
				// Read-only window, write data is discarded
				if (pwrite)
				begin
					pready <= 1'b1;
					pslverr <= 1'b1;
				end
				else if (status_hit || !in_window)
				begin
					pready <= 1'b1;
				end
				else if (lane == LANE_BAD)
				begin
					pready <= 1'b1;
					pslverr <= 1'b1;
				end
				else
				begin
					rd_en <= 1'b1;
					cache_rd <= 1'b1;
					wait_cnt <= 2'(RD_WAIT);
				end
			end
		end
	end

	// Read address, lane and status snapshot
	always_ff @(posedge clk)
	begin
		if (setup && !pready)
		begin
			rd_addr <= word;
			lane_q <= lane;
			word0_q <= (word == '0);
			if (status_hit && !pwrite)
			begin
				resp_q <= {{(APB_DW-3){1'b0}}, overflow, busy, live_sel};
			end
			else
			begin
				resp_q <= '0;
			end
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Read data
	////////////////////////////////////////////////////////////////////////////
	// Word 0 is the count view, every other word the velocity view
	always_comb
	begin
		if (word0_q)
		begin
			lane_data = (lane_q == LANE_X) ? APB_DW'(rd_word.cnt.count) : '0;
		end
		else
		begin
			case (lane_q)
				LANE_Y: lane_data = rd_word.vel.vy;
				LANE_Z: lane_data = rd_word.vel.vz;
				default: lane_data = rd_word.vel.vx;
			endcase
		end
	end

	// Bus data only while pready is up
	assign prdata = !pready ? '0 : (cache_rd ? lane_data : resp_q);

endmodule

// ==== src/velocity_cache_top.sv ====
`timescale 1ns/1ps

module velocity_cache_top
(
	input logic clk,
	input logic rst,
	input logic update_en,
	input logic rec_valid,
	input md_data_pkg::velocity_t rec_velocity,
	input md_data_pkg::cell_id_t rec_dst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cache_cfg_pkg::APB_AW-1:0] paddr,
	input logic [cache_cfg_pkg::APB_DW-1:0] pwdata,
	output logic [cache_cfg_pkg::APB_DW-1:0] prdata,
	output logic pready,
	output logic pslverr
);
	import md_data_pkg::*;
	import cache_cfg_pkg::*;

	// Shadow write side
	logic wr_en;
	logic [CACHE_AW-1:0] wr_addr;
	cache_word_u wr_word;

	// Live read side
	logic rd_en;
	logic [CACHE_AW-1:0] rd_addr;
	cache_word_u rd_word;

	// Status
	logic live_sel;
	logic busy;
	logic overflow;

	velocity_cache_ctrl i_velocity_cache_ctrl
	(
		.clk(clk),
		.rst(rst),
		.update_en(update_en),
		.rec_valid(rec_valid),
		.rec_velocity(rec_velocity),
		.rec_dst(rec_dst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_word(wr_word),
		.live_sel(live_sel),
		.busy(busy),
		.overflow(overflow)
	);

	velocity_bank_pair i_velocity_bank_pair
	(
		.clk(clk),
		.live_sel(live_sel),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_word(wr_word),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_word(rd_word)
	);

	apb_cache_port i_apb_cache_port
	(
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_word(rd_word),
		.live_sel(live_sel),
		.busy(busy),
		.overflow(overflow)
	);

endmodule

// ==== tb/velocity_cache_chk.sv ====
`timescale 1ns/1ps

module velocity_cache_chk
(
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [cache_cfg_pkg::APB_AW-1:0] paddr,
	input logic pready,
	input logic pslverr,
	input logic wr_en,
	input logic [cache_cfg_pkg::CACHE_AW-1:0] wr_addr,
	input logic live_sel,
	input logic busy,
	input logic overflow
);
	import cache_cfg_pkg::*;

	// Assertion failures so far
	int fails;

	// Setup phase of a read that goes to the buffer window
	logic cache_setup;

	initial
	begin
		fails = 0;
	end

	assign cache_setup = psel && !penable && !pwrite && !pready
		&& !paddr[STATUS_SEL_BIT]
		&& (paddr[STATUS_SEL_BIT-1 : WORD_LSB+CACHE_AW] == '0)
		&& (paddr[LANE_LSB +: 2] != LANE_BAD);

	////////////////////////////////////////////////////////////////////////////
	// APB timing
	////////////////////////////////////////////////////////////////////////////
	// Error response only on the completing cycle
	err_with_ready: assert property (@(posedge clk) disable iff (rst)
		pslverr |-> pready)
	else
	begin
		fails++;
		$error("pslverr is high while pready is low");
	end

	// Buffer latency puts pready in the third access cycle
	cache_read_wait: assert property (@(posedge clk) disable iff (rst)
		cache_setup |=> !pready ##1 !pready ##1 pready)
	else
	begin
		fails++;
		$error("cache read did not complete in its third access cycle");
	end

	////////////////////////////////////////////////////////////////////////////
	// Control
	////////////////////////////////////////////////////////////////////////////
	// busy is low exactly while the FSM is idle
	idle_no_write: assert property (@(posedge clk) disable iff (rst)
		!busy |-> !wr_en)
	else
	begin
		fails++;
		$error("shadow write while the update FSM is idle");
	end

	// Swap comes right after the count word
	swap_after_count: assert property (@(posedge clk) disable iff (rst)
		$changed(live_sel) |-> $past(wr_en && (wr_addr == '0)))
	else
	begin
		fails++;
		$error("live buffer select changed without a preceding count write");
	end

	reset_clears_overflow: assert property (@(posedge clk)
		rst |=> !overflow)
	else
	begin
		fails++;
		$error("overflow flag set right after reset");
	end

endmodule

bind velocity_cache_top velocity_cache_chk i_velocity_cache_chk
(
	.clk(clk),
	.rst(rst),
	.psel(psel),
	.penable(penable),
	.pwrite(pwrite),
	.paddr(paddr),
	.pready(pready),
	.pslverr(pslverr),
	.wr_en(wr_en),
	.wr_addr(wr_addr),
	.live_sel(live_sel),
	.busy(busy),
	.overflow(overflow)
);

// ==== tb/velocity_cache_tb.sv ====
`timescale 1ns/1ps

module velocity_cache_tb;
	import md_data_pkg::*;
	import cache_cfg_pkg::*;

	// Bounds on every wait loop
	localparam int APB_TIMEOUT = 8;
	localparam int DONE_TIMEOUT = 16;
	localparam logic [APB_AW-1:0] STATUS_ADDR = APB_AW'(1 << STATUS_SEL_BIT);

	logic clk;
	logic rst;
	logic update_en;
	logic rec_valid;
	velocity_t rec_velocity;
	cell_id_t rec_dst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [APB_AW-1:0] paddr;
	logic [APB_DW-1:0] pwdata;
	logic [APB_DW-1:0] prdata;
	logic pready;
	logic pslverr;

	// Reference model
	// shadow_q holds the update being built
	// live_q holds what the host should see
	velocity_t shadow_q[$];
	velocity_t live_q[$];
	logic live_bit;
	logic ovf_exp;

	int errors;
	int chk_fails;
	logic [APB_DW-1:0] data;
	logic err;

	velocity_cache_top i_velocity_cache_top
	(
		.clk(clk),
		.rst(rst),
		.update_en(update_en),
		.rec_valid(rec_valid),
		.rec_velocity(rec_velocity),
		.rec_dst(rec_dst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	////////////////////////////////////////////////////////////////////////////
	// Helpers
	////////////////////////////////////////////////////////////////////////////
	function automatic logic [APB_AW-1:0] cache_addr(input int word, input logic [1:0] lane);
		cache_addr = APB_AW'((word << WORD_LSB) | (int'(lane) << LANE_LSB));
	endfunction

	task automatic stop_on_timeout(input string why);
		$display("Timeout: %s", why);
		$display("TB FAILED");
		$finish;
	endtask

	task automatic check_word(input logic [APB_DW-1:0] got, input logic [APB_DW-1:0] exp,
		input string what);
		assert (got === exp)
		else
		begin
			errors++;
			$display("FAILED at %0t: %s read %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_err(input logic got, input logic exp, input string what);
		assert (got === exp)
		else
		begin
			errors++;
			$display("FAILED at %0t: %s pslverr %b, expected %b", $time, what, got, exp);
		end
	endtask

	// One APB3 transfer with setup then access until pready
	task automatic apb_transfer(input logic write, input logic [APB_AW-1:0] addr,
		input logic [APB_DW-1:0] wdata, output logic [APB_DW-1:0] rdata, output logic rerr);
		int cycles;
		logic done;
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= write;
		paddr <= addr;
		pwdata <= wdata;
		@(posedge clk);
		penable <= 1'b1;
		done = 1'b0;
		rdata = '0;
		rerr = 1'b0;
		for (cycles = 0; cycles < APB_TIMEOUT && !done; cycles++)
		begin
			@(posedge clk);
			if (pready)
			begin
				done = 1'b1;
				rdata = prdata;
				rerr = pslverr;
			end
		end
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		if (!done)
		begin
			stop_on_timeout("APB transfer never saw pready");
		end
	endtask

	task automatic check_status(input logic ov, input logic bsy, input logic live);
		logic [APB_DW-1:0] rd;
		logic rerr;
		apb_transfer(1'b0, STATUS_ADDR, '0, rd, rerr);
		check_word(rd, {{(APB_DW-3){1'b0}}, ov, bsy, live}, "status");
		check_err(rerr, 1'b0, "status read");
	endtask

	// Count word then each record lane by lane in arrival order
	task automatic check_live();
		logic [APB_DW-1:0] rd;
		logic rerr;
		apb_transfer(1'b0, cache_addr(0, LANE_X), '0, rd, rerr);
		check_word(rd, APB_DW'(live_q.size()), "count word");
		check_err(rerr, 1'b0, "count read");
		for (int i = 0; i < live_q.size(); i++)
		begin
			apb_transfer(1'b0, cache_addr(i + 1, LANE_X), '0, rd, rerr);
			check_word(rd, live_q[i].vx, $sformatf("word %0d vx", i + 1));
			check_err(rerr, 1'b0, "vx read");
			apb_transfer(1'b0, cache_addr(i + 1, LANE_Y), '0, rd, rerr);
			check_word(rd, live_q[i].vy, $sformatf("word %0d vy", i + 1));
			apb_transfer(1'b0, cache_addr(i + 1, LANE_Z), '0, rd, rerr);
			check_word(rd, live_q[i].vz, $sformatf("word %0d vz", i + 1));
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Broadcast stimulus
	////////////////////////////////////////////////////////////////////////////
	// Starts an update with n beats
	// match_pct percent of them go to this cell
	// update_en stays high afterwards
	task automatic send_beats(input int n, input int match_pct);
		velocity_t v;
		cell_id_t d;
		logic hit;
		shadow_q.delete();
		ovf_exp = 1'b0;
		for (int i = 0; i < n; i++)
		begin
			v.vx = $urandom();
			v.vy = $urandom();
			v.vz = $urandom();
			hit = (int'($urandom_range(99)) < match_pct);
			if (hit)
			begin
				d = cell_id_t'(MY_CELL);
			end
			else
			begin
				d = cell_id_t'($urandom_range(4095));
				// Nudge a random hit off this cell
				if (d == cell_id_t'(MY_CELL))
					d.cell_x = d.cell_x ^ 4'd1;
			end
			@(posedge clk);
			update_en <= 1'b1;
			rec_valid <= 1'b1;
			rec_velocity <= v;
			rec_dst <= d;
			if (hit)
			begin
				if (shadow_q.size() < CACHE_CAPACITY)
					shadow_q.push_back(v);
				else
					ovf_exp = 1'b1;
			end
		end
		@(posedge clk);
		rec_valid <= 1'b0;
	endtask

	// Drop update_en and poll status until busy falls
	task automatic finish_update();
		logic [APB_DW-1:0] rd;
		logic rerr;
		logic idle;
		@(posedge clk);
		update_en <= 1'b0;
		rec_valid <= 1'b0;
		idle = 1'b0;
		for (int k = 0; k < DONE_TIMEOUT && !idle; k++)
		begin
			apb_transfer(1'b0, STATUS_ADDR, '0, rd, rerr);
			idle = !rd[1];
		end
		if (!idle)
		begin
			stop_on_timeout("busy never fell after the update ended");
		end
		else
		begin
			live_q = shadow_q;
			live_bit = ~live_bit;
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////////////////////
	initial
	begin
		void'($urandom(32'h2cb2));
		rst = 1'b1;
		update_en = 1'b0;
		rec_valid = 1'b0;
		rec_velocity = '0;
		rec_dst = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = '0;
		errors = 0;
		live_bit = 1'b0;
		ovf_exp = 1'b0;
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		check_status(1'b0, 1'b0, 1'b0);

		// Mixed destinations then full readback
		send_beats($urandom_range(40, 20), 50);
		finish_update();
		check_status(ovf_exp, 1'b0, live_bit);
		check_live();

		// Host still sees the first update while the second is in flight
		send_beats($urandom_range(40, 20), 50);
		check_status(1'b0, 1'b1, live_bit);
		check_live();
		finish_update();
		check_status(ovf_exp, 1'b0, live_bit);
		check_live();

		// Nothing for this cell
		send_beats(12, 0);
		finish_update();
		check_status(1'b0, 1'b0, live_bit);
		check_live();

		// Write and lane 3 both get an error response
		apb_transfer(1'b1, cache_addr(1, LANE_X), $urandom(), data, err);
		check_err(err, 1'b1, "APB write");
		apb_transfer(1'b0, cache_addr(1, LANE_BAD), '0, data, err);
		check_err(err, 1'b1, "lane 3 read");

		// Only 63 of 70 matches are kept
		send_beats(70, 100);
		finish_update();
		check_status(1'b1, 1'b0, live_bit);
		check_live();

		// Next update clears the flag at its start
		send_beats(6, 50);
		check_status(1'b0, 1'b1, live_bit);
		finish_update();
		check_status(1'b0, 1'b0, live_bit);
		check_live();

		repeat (4) @(posedge clk);
		chk_fails = i_velocity_cache_top.i_velocity_cache_chk.fails;
		$display("Checks done: %0d value errors, %0d assertion failures", errors, chk_fails);
		if (errors == 0 && chk_fails == 0)
		begin
			$display("TB PASSED");
		end
		else
		begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

// ==== files.f ====
src/md_data_pkg.sv
src/cache_cfg_pkg.sv
src/cell_buffer_ram.sv
src/velocity_bank_pair.sv
src/velocity_cache_ctrl.sv
src/apb_cache_port.sv
src/velocity_cache_top.sv
tb/velocity_cache_chk.sv
tb/velocity_cache_tb.sv

// ==== Bender.yml ====
package:
  name: velocity_cache

sources:
  - src/md_data_pkg.sv
  - src/cache_cfg_pkg.sv
  - src/cell_buffer_ram.sv
  - src/velocity_bank_pair.sv
  - src/velocity_cache_ctrl.sv
  - src/apb_cache_port.sv
  - src/velocity_cache_top.sv
  - target: simulation
    files:
      - tb/velocity_cache_chk.sv
      - tb/velocity_cache_tb.sv
